//--- build.f
verilog/fp_format_pkg.sv
verilog/fpu_op_pkg.sv
verilog/fpu_op_decoder.sv
verilog/fp_compare_unit.sv
verilog/fp_sign_class_unit.sv
verilog/fpu_sequencer.sv
verilog/fpu_misc_top.sv
verif/fpu_tb_clock.sv
verif/fpu_misc_asserts.sv
verif/fpu_misc_tb.sv

//--- Makefile
# verilator build and run of the fpu testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = fpu_misc_tb
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/fpu_misc_tb.sv
`timescale 1ns/100ps
// fpu top testbench
// every op over a grid of special values, lcg operands and invalid encodings
module fpu_misc_tb;
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    localparam int          timeout_cycles = 64;     // bound on every wait
    localparam logic [31:0] lcg_seed       = 32'h96f0_fc8d;

    // {funct7 code, funct3} of every decodable op
    localparam logic [6:0] valid_ops [9] = '{
        7'b1101_010, 7'b1101_001, 7'b1101_000,       // feq flt fle
        7'b1000_000, 7'b1000_001,                    // fmin fmax
        7'b0111_000, 7'b0111_001, 7'b0111_010,       // fsgnj fsgnjn fsgnjx
        7'b1011_001                                  // fclass with rs2 = 0
    };
    localparam fp_word_t specials [12] = '{
        32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,  // +0 -0 +inf -inf
        32'h7fc0_0000, 32'hffc0_0123, 32'h7f80_0001, 32'hffa0_0000,  // two qnan, two snan
        32'h0000_0001, 32'h807f_ffff, 32'h3f80_0000, 32'hc049_0fdb   // subnormals, normals
    };

    logic         clk, arst_n;
    logic         start, ready, nv;
    format_t      format_type;
    logic [2:0]   sub_format_type;
    funct3_t      funct3;
    funct7_code_t funct7_out;
    rs2_sel_t     rs2_add;
    fp_word_t     in1, in2, out;

    logic [31:0]  rng;
    logic         check_en;                          // compare process armed
    fp_word_t     exp_out;
    logic         exp_nv;

    fpu_tb_clock u_clk (.clk(clk), .arst_n(arst_n));
    fpu_misc_top dut0 (.*);
    bind fpu_misc_top fpu_misc_asserts u_asserts (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // negatives flipped so an unsigned compare orders them with -0 below +0
    function automatic logic [31:0] order_key(input fp_word_t x);
        return x[31] ? ~x : (x | 32'h8000_0000);
    endfunction

    function automatic int class_bit(input fp_word_t x);
        if (x[30:23] == 8'hff) return (x[22:0] == '0) ? (x[31] ? cls_neg_inf : cls_pos_inf)
                                                      : (x[22] ? cls_qnan : cls_snan);
        if (x[30:23] == 8'h00) return (x[22:0] == '0) ? (x[31] ? cls_neg_zero : cls_pos_zero)
                                                      : (x[31] ? cls_neg_sub : cls_pos_sub);
        return x[31] ? cls_neg_norm : cls_pos_norm;
    endfunction

    // expected {nv, out} from the instruction table
    function automatic logic [32:0] ref_model(input logic [6:0] code, input fp_word_t a,
                                              input fp_word_t b);
        logic     na, nb, sig, eq, lt, v;
        fp_word_t r;
        na  = (a[30:23] == 8'hff) && (a[22:0] != '0);
        nb  = (b[30:23] == 8'hff) && (b[22:0] != '0);
        sig = (na && !a[22]) || (nb && !b[22]);      // some operand is a signalling nan
        eq  = (a == b);
        lt  = order_key(a) < order_key(b);
        case (code)
            7'b1101_010: r = {31'b0, eq && !na && !nb};
            7'b1101_001: r = {31'b0, lt && !na && !nb};
            7'b1101_000: r = {31'b0, (lt || eq) && !na && !nb};
            7'b1000_000: r = (na && nb) ? canonical_nan : na ? b : nb ? a : (lt || eq) ? a : b;
            7'b1000_001: r = (na && nb) ? canonical_nan : na ? b : nb ? a : lt ? b : a;
            7'b0111_000: r = {b[31], a[30:0]};
            7'b0111_001: r = {~b[31], a[30:0]};
            7'b0111_010: r = {a[31] ^ b[31], a[30:0]};
            7'b1011_001: r = 32'd1 << class_bit(a);
            default:     r = '0;
        endcase
        case (code[6:3])
            4'b1101: v = (code[2:0] == 3'b010) ? sig : (na || nb);  // only feq is quiet
            4'b1000: v = sig;
            default: v = 1'b0;
        endcase
        return {v, r};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("failure at %0t ns: %s", $time, why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // one decodable op through the whole handshake and back to idle
    task automatic run_valid(input logic [6:0] code, input fp_word_t a, input fp_word_t b);
        logic [32:0] expv;
        int          waited;
        int          hold;
        expv = ref_model(code, a, b);
        {format_type, sub_format_type, funct7_out, funct3, rs2_add} = {fmt_r, 3'b000, code, 5'd0};
        in1      = a;
        in2      = b;
        exp_out  = expv[31:0];
        exp_nv   = expv[32];
        check_en = 1'b1;
        start    = 1'b1;
        waited   = 0;
        while (!ready && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) stop_run("ready did not rise while start was held");
        check_value("start to ready latency", waited, 32'd1);
        rng  = lcg_step(rng);
        hold = 1 + int'(rng[31:24]) % 5;             // 1 to 5 extra cycles held
        repeat (hold) @(negedge clk);
        start    = 1'b0;
        check_en = 1'b0;
        @(negedge clk);
        check_value("ready after start drop", {31'b0, ready}, 32'd0);
    endtask

    // ready must stay low for 16 cycles with start held
    task automatic run_invalid(input format_t fmt, input logic [2:0] sub,
                               input funct7_code_t f7, input funct3_t f3, input rs2_sel_t rs2);
        int i;
        rng = lcg_step(rng);
        {format_type, sub_format_type, funct7_out, funct3, rs2_add} = {fmt, sub, f7, f3, rs2};
        in1   = rng;
        in2   = ~rng;
        start = 1'b1;
        for (i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("ready on invalid op", {31'b0, ready}, 32'd0);
        end
        start = 1'b0;
        @(negedge clk);
    endtask

    // compare process checks every rising edge while a result is shown
    always @(posedge clk) begin
        if (check_en && ready) begin
            check_value("out", out, exp_out);
            check_value("nv", {31'b0, nv}, {31'b0, exp_nv});
        end
    end

    initial begin
        int       waited;
        int       k;
        fp_word_t a;
        fp_word_t b;
        {start, format_type, sub_format_type, funct3, funct7_out, rs2_add} = '0;
        in1      = '0;
        in2      = '0;
        check_en = 1'b0;
        exp_out  = '0;
        exp_nv   = 1'b0;
        rng      = lcg_seed;
        waited   = 0;
        while ((arst_n !== 1'b1) && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (arst_n !== 1'b1) stop_run("reset was never released");
        @(negedge clk);
        check_value("ready after reset", {31'b0, ready}, 32'd0);
        check_value("out after reset", out, 32'd0);
        for (k = 0; k < 9 * 144; k++) begin          // every op over every ordered special pair
            run_valid(valid_ops[k / 144], specials[(k / 12) % 12], specials[k % 12]);
        end
        for (k = 0; k < 400; k++) begin
            rng = lcg_step(rng);
            a   = rng;
            rng = lcg_step(rng);
            b   = (rng[31:29] == 3'd0) ? a : rng;    // equal pair now and then
            rng = lcg_step(rng);
            if (rng[31:29] == 3'd1) a = specials[int'(rng[27:24]) % 12];
            run_valid(valid_ops[int'(rng[15:8]) % 9], a, b);
        end
        run_invalid(fmt_r4, 3'b000, 4'b1101, 3'b010, 5'd0);     // r4 format
        run_invalid(fmt_r, 3'b010, 4'b1101, 3'b010, 5'd0);      // nonzero sub-format
        run_invalid(fmt_r, 3'b000, 4'b0000, 3'b000, 5'd0);      // arithmetic code
        run_invalid(fmt_r, 3'b000, 4'b0011, 3'b000, 5'd0);
        run_invalid(fmt_r, 3'b000, 4'b0111, 3'b011, 5'd0);      // unknown funct3 for sign
        run_invalid(fmt_r, 3'b000, 4'b1000, 3'b010, 5'd0);      // min/max
        run_invalid(fmt_r, 3'b000, 4'b1101, 3'b011, 5'd0);      // compare
        run_invalid(fmt_r, 3'b000, 4'b1011, 3'b000, 5'd0);      // class
        run_invalid(fmt_r, 3'b000, 4'b1011, 3'b001, 5'd3);      // fclass with rs2 != 0
        run_valid(valid_ops[0], specials[10], specials[10]);    // still alive after invalids
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- verif/fpu_misc_asserts.sv
`timescale 1ns/100ps
// handshake checks on the fpu top
// bound into fpu_misc_top, reports through failing assertions only
module fpu_misc_asserts (
    input logic                    clk,
    input logic                    arst_n,
    input logic                    start,
    input logic                    ready,
    input fp_format_pkg::fp_word_t out,
    input logic                    nv
);
    // ready only comes up after start was seen on the edge before
    ready_after_start: assert property (
        @(posedge clk) disable iff (!arst_n) $rose(ready) |-> $past(start)
    ) else $error("ready rose without start on the previous edge");

    idle_outputs_zero: assert property (
        @(posedge clk) disable iff (!arst_n) !ready |-> ((out == '0) && !nv)
    ) else $error("out or nv not cleared while ready is low");

    // result held while the requester keeps start up
    result_held: assert property (
        @(posedge clk) disable iff (!arst_n)
            (ready && $past(ready && start)) |-> ($stable(out) && $stable(nv))
    ) else $error("out changed while ready and start stayed high");

endmodule

//--- verif/fpu_tb_clock.sv
`timescale 1ns/100ps
// testbench clock and reset
// 10 ns clock, arst_n held low for 8 cycles
module fpu_tb_clock (
    output logic clk,
    output logic arst_n
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;              // 10 ns period
    end

    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                      // released away from the rising edge
    end
endmodule

//--- verilog/fpu_misc_top.sv
`timescale 1ns/100ps
// non-arithmetic fpu top
// decoder, compare unit, sign/class unit and the handshake sequencer
module fpu_misc_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     start,
    input  fpu_op_pkg::format_t      format_type,
    input  logic [2:0]               sub_format_type,
    input  fpu_op_pkg::funct3_t      funct3,
    input  fpu_op_pkg::funct7_code_t funct7_out,
    input  fpu_op_pkg::rs2_sel_t     rs2_add,
    input  fp_format_pkg::fp_word_t  in1,
    input  fp_format_pkg::fp_word_t  in2,
    output logic                     ready,
    output fp_format_pkg::fp_word_t  out,
    output logic                     nv
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    fpu_option_t option;                // decoded op, shared by all blocks
    fp_word_t    cmp_result;
    fp_word_t    sc_result;
    logic        cmp_nv;

    fpu_op_decoder u_dec (
        .format_type     (format_type),
        .sub_format_type (sub_format_type),
        .funct3          (funct3),
        .funct7_out      (funct7_out),
        .rs2_add         (rs2_add),
        .option          (option)
    );

    fp_compare_unit u_cmp (
        .option (option),
        .in1    (in1),
        .in2    (in2),
        .result (cmp_result),
        .nv     (cmp_nv)
    );

    fp_sign_class_unit u_sc (
        .option (option),
        .in1    (in1),
        .in2    (in2),
        .result (sc_result)
    );

    fpu_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .option     (option),
        .cmp_result (cmp_result),
        .cmp_nv     (cmp_nv),
        .sc_result  (sc_result),
        .ready      (ready),
        .out        (out),
        .nv         (nv)
    );

endmodule

//--- verilog/fpu_sequencer.sv
`timescale 1ns/100ps
// fpu sequencer
// start/ready handshake, latches the unit group on start and muxes the result out
module fpu_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    start,
    input  fpu_op_pkg::fpu_option_t option,
    input  fp_format_pkg::fp_word_t cmp_result,
    input  logic                    cmp_nv,
    input  fp_format_pkg::fp_word_t sc_result,
    output logic                    ready,
    output fp_format_pkg::fp_word_t out,
    output logic                    nv
);
    import fpu_op_pkg::*;

    typedef enum logic {
        st_idle,
        st_done
    } seq_state_t;

    seq_state_t  state, state_nxt;
    unit_group_t grp, grp_nxt;
    unit_group_t opt_grp;                           // group of the incoming option

    // group from the option's group bits, invalid maps to none
    always_comb begin
        if (option[3:2] == 2'b10)           opt_grp = grp_compare;     // 1_10 and 0_10
        else if (option[4:2] == 3'b011)     opt_grp = grp_sign_class;  // 0_11
        else                                opt_grp = grp_none;
    end

    always_comb begin
        state_nxt = state;
        grp_nxt   = grp;
        case (state)
            st_idle: begin
                if (start && (opt_grp != grp_none)) begin   // invalid op never leaves idle
                    state_nxt = st_done;
                    grp_nxt   = opt_grp;
                end
            end
            st_done: begin
                if (!start) begin                   // requester saw ready and let go
                    state_nxt = st_idle;
                    grp_nxt   = grp_none;
                end
            end
            default: begin
                state_nxt = st_idle;
                grp_nxt   = grp_none;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            grp   <= grp_none;
        end else begin
            state <= state_nxt;
            grp   <= grp_nxt;
        end
    end

    assign ready = (state == st_done);

    // operands held by the requester, so units stay valid while in st_done
    always_comb begin
        out = '0;
        nv  = 1'b0;
        if (ready) begin
            case (grp)
                grp_compare: begin
                    out = cmp_result;
                    nv  = cmp_nv;
                end
                grp_sign_class: out = sc_result;   // never invalid
                default:        out = '0;
            endcase
        end
    end

endmodule

//--- verilog/fp_sign_class_unit.sv
`timescale 1ns/100ps
// fp sign injection and classify unit
// fsgnj/fsgnjn/fsgnjx keep in1's magnitude, fclass gives a one-hot class mask of in1
module fp_sign_class_unit (
    input  fpu_op_pkg::fpu_option_t option,
    input  fp_format_pkg::fp_word_t in1,
    input  fp_format_pkg::fp_word_t in2,
    output fp_format_pkg::fp_word_t result
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    logic        sign1, sign2;
    fp_exp_t     exp1;
    fp_man_t     man1;
    class_mask_t cls;

    assign sign1 = in1[exp_w+man_w];
    assign sign2 = in2[exp_w+man_w];
    assign exp1  = in1[man_w +: exp_w];
    assign man1  = in1[man_w-1:0];

    always_comb begin
        cls = '0;
        if (exp1 == '0) begin                       // zero or subnormal
            if (man1 == '0) cls[sign1 ? cls_neg_zero : cls_pos_zero] = 1'b1;
            else            cls[sign1 ? cls_neg_sub  : cls_pos_sub]  = 1'b1;
        end else if (exp1 == '1) begin              // inf or nan
            if (man1 == '0)          cls[sign1 ? cls_neg_inf : cls_pos_inf] = 1'b1;
            else if (man1[quiet_bit]) cls[cls_qnan] = 1'b1;   // nan sign ignored
            else                      cls[cls_snan] = 1'b1;
        end else begin
            cls[sign1 ? cls_neg_norm : cls_pos_norm] = 1'b1;
        end
    end

    always_comb begin
        case (option)
            opt_fsgnj:  result = {sign2, in1[exp_w+man_w-1:0]};
            opt_fsgnjn: result = {~sign2, in1[exp_w+man_w-1:0]};
            opt_fsgnjx: result = {sign1 ^ sign2, in1[exp_w+man_w-1:0]};
            opt_fclass: result = fp_word_t'(cls);  // zero-extended mask
            default:    result = '0;
        endcase
    end

endmodule

//--- verilog/fp_compare_unit.sv
`timescale 1ns/100ps
// fp compare unit
// feq/flt/fle and fmin/fmax on binary32 operands, with the invalid flag
module fp_compare_unit (
    input  fpu_op_pkg::fpu_option_t option,
    input  fp_format_pkg::fp_word_t in1,
    input  fp_format_pkg::fp_word_t in2,
    output fp_format_pkg::fp_word_t result,
    output logic                    nv
);
    import fp_format_pkg::*;
    import fpu_op_pkg::*;

    logic    sign1, sign2;
    fp_exp_t exp1, exp2;
    fp_man_t man1, man2;
    logic    nan1, nan2, snan1, snan2;
    logic    any_nan, any_snan;
    logic    eq, lt;

    assign sign1 = in1[exp_w+man_w];
    assign sign2 = in2[exp_w+man_w];
    assign exp1  = in1[man_w +: exp_w];
    assign exp2  = in2[man_w +: exp_w];
    assign man1  = in1[man_w-1:0];
    assign man2  = in2[man_w-1:0];

    assign nan1  = (exp1 == '1) && (man1 != '0);   // all-ones exponent, nonzero payload
    assign nan2  = (exp2 == '1) && (man2 != '0);
    assign snan1 = nan1 && !man1[quiet_bit];        // quiet bit clear -> signalling
    assign snan2 = nan2 && !man2[quiet_bit];

    assign any_nan  = nan1 | nan2;
    assign any_snan = snan1 | snan2;

    assign eq = (in1 == in2);                       // bit equality, -0 and +0 differ

    // magnitude compare on {exp, man}, order flips for negatives
    always_comb begin
        if (sign1 != sign2) begin
            lt = sign1;                             // negative one is smaller
        end else if ({exp1, man1} == {exp2, man2}) begin
            lt = 1'b0;                              // equal is never less
        end else begin
            lt = sign1 ^ ({exp1, man1} < {exp2, man2});
        end
    end

    always_comb begin
        result = '0;
        nv     = 1'b0;
        case (option)
            opt_feq: begin
                result = fp_word_t'(eq && !any_nan);
                nv     = any_snan;                  // quiet compare
            end
            opt_flt: begin
                result = fp_word_t'(lt && !any_nan);
                nv     = any_nan;                   // signalling compare
            end
            opt_fle: begin
                result = fp_word_t'((lt || eq) && !any_nan);
                nv     = any_nan;
            end
            opt_fmin: begin
                if (nan1 && nan2)  result = canonical_nan;
                else if (nan1)     result = in2;    // single nan passes the other
                else if (nan2)     result = in1;
                else               result = (lt || eq) ? in1 : in2;
                nv = any_snan;
            end
            opt_fmax: begin
                if (nan1 && nan2)  result = canonical_nan;
                else if (nan1)     result = in2;
                else if (nan2)     result = in1;
                else               result = lt ? in2 : in1;
                nv = any_snan;
            end
            default: begin
                result = '0;                        // other groups not served here
                nv     = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/fpu_op_decoder.sv
`timescale 1ns/100ps
// fpu op decoder
// maps format, funct7 code, funct3 and rs2 to an fpu_option code, combinational
module fpu_op_decoder (
    input  fpu_op_pkg::format_t      format_type,
    input  logic [2:0]               sub_format_type,
    input  fpu_op_pkg::funct3_t      funct3,
    input  fpu_op_pkg::funct7_code_t funct7_out,
    input  fpu_op_pkg::rs2_sel_t     rs2_add,
    output fpu_op_pkg::fpu_option_t  option
);
    import fpu_op_pkg::*;

    localparam funct7_code_t f7_sign   = 4'b0111;   // funct7 0010000
    localparam funct7_code_t f7_minmax = 4'b1000;   // funct7 0010100
    localparam funct7_code_t f7_class  = 4'b1011;   // funct7 1110000
    localparam funct7_code_t f7_cmp    = 4'b1101;   // funct7 1010000

    always_comb begin
        option = opt_invalid;                           // default for every unknown code
        case (format_type)
            fmt_r: begin
                if (sub_format_type == 3'b000) begin    // sub-format only meaningful for r4
                    case (funct7_out)
                        f7_sign: begin
                            case (funct3)
                                3'b000:  option = opt_fsgnj;
                                3'b001:  option = opt_fsgnjn;
                                3'b010:  option = opt_fsgnjx;
                                default: option = opt_invalid;
                            endcase
                        end
                        f7_minmax: begin
                            case (funct3)
                                3'b000:  option = opt_fmin;
                                3'b001:  option = opt_fmax;
                                default: option = opt_invalid;
                            endcase
                        end
                        f7_cmp: begin
                            case (funct3)
                                3'b000:  option = opt_fle;
                                3'b001:  option = opt_flt;
                                3'b010:  option = opt_feq;
                                default: option = opt_invalid;
                            endcase
                        end
                        f7_class: begin
                            // rs2 must be x0 for fclass
                            if ((funct3 == 3'b001) && (rs2_add == '0)) begin
                                option = opt_fclass;
                            end
                        end
                        default: option = opt_invalid;  // arithmetic and convert codes land here
                    endcase
                end
            end
            fmt_r4:  option = opt_invalid;              // no fused multiply-add unit
            default: option = opt_invalid;              // i/s types belong to the lsu
        endcase
    end

endmodule

//--- verilog/fpu_op_pkg.sv
// fpu operation package
// instruction field types, decoded operation codes and unit group codes
package fpu_op_pkg;

    typedef logic [2:0] format_t;       // instruction format from the main decoder
    typedef logic [3:0] funct7_code_t;  // compressed funct7
    typedef logic [2:0] funct3_t;
    typedef logic [4:0] rs2_sel_t;
    typedef logic [4:0] fpu_option_t;   // decoded op, layout x_gg_ss

    localparam format_t fmt_r  = 3'b000;    // register-register
    localparam format_t fmt_r4 = 3'b001;    // fused multiply-add, no unit here

    // compare group 1_10_xx
    localparam fpu_option_t opt_fle     = 5'b1_10_00;
    localparam fpu_option_t opt_flt     = 5'b1_10_01;
    localparam fpu_option_t opt_feq     = 5'b1_10_10;

    // min/max group 0_10_0x
    localparam fpu_option_t opt_fmin    = 5'b0_10_00;
    localparam fpu_option_t opt_fmax    = 5'b0_10_01;

    // sign injection and class share 0_11_xx
    localparam fpu_option_t opt_fsgnj   = 5'b0_11_00;
    localparam fpu_option_t opt_fsgnjn  = 5'b0_11_01;
    localparam fpu_option_t opt_fsgnjx  = 5'b0_11_10;
    localparam fpu_option_t opt_fclass  = 5'b0_11_11;

    localparam fpu_option_t opt_invalid = 5'b1_11_11;   // never starts the sequencer

    // which unit drives the output while ready is high
    typedef enum logic [1:0] {
        grp_none,
        grp_compare,        // feq/flt/fle and fmin/fmax
        grp_sign_class      // fsgnj* and fclass
    } unit_group_t;

endpackage

//--- verilog/fp_format_pkg.sv
// binary32 format package
// field widths, word types, fclass mask bit positions and the canonical quiet nan
package fp_format_pkg;

    localparam int exp_w = 8;                   // exponent field width
    localparam int man_w = 23;                  // stored mantissa, hidden bit not kept

    typedef logic [exp_w+man_w:0] fp_word_t;    // sign + exponent + mantissa
    typedef logic [exp_w-1:0]     fp_exp_t;
    typedef logic [man_w-1:0]     fp_man_t;

    // fclass result bits, one hot
    localparam int cls_neg_inf  = 0;
    localparam int cls_neg_norm = 1;
    localparam int cls_neg_sub  = 2;
    localparam int cls_neg_zero = 3;
    localparam int cls_pos_zero = 4;
    localparam int cls_pos_sub  = 5;
    localparam int cls_pos_norm = 6;
    localparam int cls_pos_inf  = 7;
    localparam int cls_snan     = 8;
    localparam int cls_qnan     = 9;            // top bit of the mask

    typedef logic [cls_qnan:0] class_mask_t;    // 10 bit fclass mask

    localparam fp_word_t canonical_nan = 32'h7fc0_0000;   // positive quiet nan, zero payload
    localparam int       quiet_bit     = man_w - 1;       // mantissa msb, set on qnan

endpackage
